//--- dmac_top.f
+incdir+.
dmac_pkg.sv
dmac_regs.sv
dmac_fifo.sv
cpu_bus_sm.sv
dmac_top.sv
dmac_tb_clock.sv
dmac_assert.sv
dmac_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the dma controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f dmac_top.f --top-module dmac_tb -o dmac_sim

out=$(./obj_dir/dmac_sim)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

//--- dmac_tb.sv
// testbench for the dma controller with a random memory responder and a reference memory
`timescale 1ns/1ps
`include "dmac_defines.svh"

module dmac_tb;

    logic                BCLK;
    logic                CCRESET_;
    logic                reg_wr;
    logic [1:0]          reg_addr;
    dmac_pkg::word_t     reg_wdata;
    dmac_pkg::word_t     reg_rdata;
    logic                periph_push;
    dmac_pkg::word_t     periph_wdata;
    logic                periph_pop;
    dmac_pkg::word_t     periph_rdata;
    logic                periph_avail;
    logic                bus_req;
    logic                bgack;
    dmac_pkg::cpu_bus_t  bus_out;
    logic                bus_grant;
    logic [1:0]          dsack;
    logic                sterm;
    dmac_pkg::word_t     bus_rdata;
    logic                irq;

    integer              seed;
    int                  errors;
    int                  checks;
    int                  cycles;
    int                  limit;
    int                  len [0:3];
    dmac_pkg::word_t     mem_model [0:4095];

    dmac_tb_clock u_clock (
        .BCLK     (BCLK),
        .CCRESET_ (CCRESET_)
    );

    dmac_top DUT (
        .BCLK         (BCLK),
        .CCRESET_     (CCRESET_),
        .reg_wr       (reg_wr),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .periph_push  (periph_push),
        .periph_wdata (periph_wdata),
        .periph_pop   (periph_pop),
        .periph_rdata (periph_rdata),
        .periph_avail (periph_avail),
        .bus_req      (bus_req),
        .bgack        (bgack),
        .bus_out      (bus_out),
        .bus_grant    (bus_grant),
        .dsack        (dsack),
        .sterm        (sterm),
        .bus_rdata    (bus_rdata),
        .irq          (irq)
    );

    function automatic int rand_below(input int n);
        rand_below = int'($unsigned($random(seed)) % n);
    endfunction

    task automatic step();
        @(posedge BCLK);
        #1;
    endtask

    task automatic check_value(input string what, input dmac_pkg::word_t got,
                               input dmac_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic reg_write(input logic [1:0] a, input dmac_pkg::word_t d);
        reg_wr    = 1'b1;
        reg_addr  = a;
        reg_wdata = d;
        step();
        reg_wr = 1'b0;
    endtask

    task automatic reg_read(input logic [1:0] a, output dmac_pkg::word_t d);
        reg_addr = a;
        step();
        d = reg_rdata;
    endtask

    task automatic start_transfer(input dmac_pkg::addr_t a, input int n, input logic dir);
        reg_write(`DMAC_REG_ADDR, a);
        reg_write(`DMAC_REG_CNT, dmac_pkg::word_t'(n));
        reg_write(`DMAC_REG_CTRL, {29'd0, 1'b1, dir, 1'b1});
    endtask

    // check the final position and clear status so irq falls
    task automatic finish_checks(input dmac_pkg::addr_t a, input int n);
        dmac_pkg::word_t v;
        reg_read(`DMAC_REG_ADDR, v);
        check_value("ADDR after transfer", v, a + 32'(4 * n));
        reg_read(`DMAC_REG_CNT, v);
        check_value("CNT after transfer", v, 32'd0);
        reg_write(`DMAC_REG_STAT, 32'd1);
        step();
        step();
        reg_read(`DMAC_REG_STAT, v);
        check_value("STAT after clear", v, 32'd0);
    endtask

    task automatic check_memory(input dmac_pkg::addr_t a, input dmac_pkg::word_t words[$]);
        for (int i = 0; i < words.size(); i++) begin
            check_value("memory word", mem_model[a[13:2] + 12'(i)], words[i]);
        end
    endtask

    task automatic run_p2m(input dmac_pkg::addr_t a, input int n);
        dmac_pkg::word_t words[$];
        dmac_pkg::word_t v;
        int              pushed;
        for (int i = 0; i < n; i++) begin
            words.push_back($random(seed));
        end
        pushed = 0;
        start_transfer(a, n, 1'b0);
        while ((pushed < n) || !irq) begin
            reg_read(`DMAC_REG_CNT, v);
            // words in the fifo are those pushed minus those the bus master counted off
            if ((pushed < n) && ((pushed - (n - int'(v))) < `DMAC_FIFO_DEPTH)) begin
                periph_push  = 1'b1;
                periph_wdata = words[pushed];
                pushed++;
            end
            step();
            periph_push = 1'b0;
        end
        check_memory(a, words);
        finish_checks(a, n);
    endtask

    task automatic run_m2p(input dmac_pkg::addr_t a, input int n);
        int popped;
        for (int i = 0; i < n; i++) begin
            mem_model[a[13:2] + 12'(i)] = $random(seed);
        end
        popped = 0;
        start_transfer(a, n, 1'b1);
        while ((popped < n) || !irq) begin
            if (periph_avail && (popped < n)) begin
                check_value("peripheral word", periph_rdata, mem_model[a[13:2] + 12'(popped)]);
                periph_pop = 1'b1;
                popped++;
            end
            step();
            periph_pop = 1'b0;
        end
        finish_checks(a, n);
    endtask

    task automatic run_overflow(input dmac_pkg::addr_t a);
        dmac_pkg::word_t accepted[$];
        dmac_pkg::word_t w;
        dmac_pkg::word_t v;
        int              level;
        reg_write(`DMAC_REG_CTRL, 32'd0);
        level = 0;
        for (int k = 0; k < `DMAC_FIFO_DEPTH + 3; k++) begin
            w            = $random(seed);
            periph_push  = 1'b1;
            periph_wdata = w;
            if (level < `DMAC_FIFO_DEPTH) begin
                accepted.push_back(w);
                level++;
            end
            step();
        end
        periph_push = 1'b0;
        step();
        step();
        reg_read(`DMAC_REG_STAT, v);
        check_value("STAT overflow bit", {31'd0, v[`DMAC_STAT_OVF]}, 32'd1);
        start_transfer(a, level, 1'b0);
        while (!irq) begin
            step();
        end
        check_memory(a, accepted);
        finish_checks(a, level);
    endtask

    // bus arbiter and memory responder
    initial begin
        int  gwait;
        int  twait;
        logic granting;
        logic counting;
        logic active;
        logic [11:0] wa;
        bus_grant = 1'b0;
        dsack     = 2'b00;
        sterm     = 1'b0;
        bus_rdata = '0;
        granting  = 1'b0;
        counting  = 1'b0;
        active    = 1'b0;
        forever begin
            step();
            if (bus_grant && bgack) begin
                bus_grant = 1'b0;
            end else if (!bus_grant && bus_req) begin
                if (!granting) begin
                    granting = 1'b1;
                    gwait    = rand_below(4);
                end
                if (gwait == 0) begin
                    bus_grant = 1'b1;
                    granting  = 1'b0;
                end else begin
                    gwait--;
                end
            end
            if (!bus_out.ds) begin
                dsack    = 2'b00;
                sterm    = 1'b0;
                active   = 1'b0;
                counting = 1'b0;
            end else if (!active) begin
                if (!counting) begin
                    counting = 1'b1;
                    twait    = rand_below(5);
                end
                if (twait == 0) begin
                    active   = 1'b1;
                    counting = 1'b0;
                    wa       = bus_out.addr[13:2];
                    if (bus_out.addr[12]) begin
                        // 16-bit port moves both halves on D31:16
                        dsack = 2'b10;
                        if (bus_out.rw) begin
                            bus_rdata = bus_out.addr[1] ? {mem_model[wa][15:0], 16'h0}
                                                        : {mem_model[wa][31:16], 16'h0};
                        end else if (bus_out.addr[1]) begin
                            mem_model[wa][15:0] = bus_out.wdata[31:16];
                        end else begin
                            mem_model[wa][31:16] = bus_out.wdata[31:16];
                        end
                    end else begin
                        if (rand_below(2) == 1) begin
                            sterm = 1'b1;
                        end else begin
                            dsack = 2'b11;
                        end
                        if (bus_out.rw) begin
                            bus_rdata = mem_model[wa];
                        end else begin
                            mem_model[wa] = bus_out.wdata;
                        end
                    end
                end else begin
                    twait--;
                end
            end
        end
    end

    always @(posedge BCLK) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, a transfer never completed", limit);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        dmac_pkg::word_t v;
        dmac_pkg::word_t w;
        seed         = 32'h4454_9cdb;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        reg_wr       = 1'b0;
        reg_addr     = 2'd0;
        reg_wdata    = '0;
        periph_push  = 1'b0;
        periph_wdata = '0;
        periph_pop   = 1'b0;
        for (int i = 0; i < 4096; i++) begin
            mem_model[i] = 32'hA5C3_0000 ^ (i * 32'h0001_0007);
        end
        for (int i = 0; i < 4; i++) begin
            len[i] = 4 + rand_below(9);
        end
        // room for each word plus register setup around every transfer
        limit = (len[0] + len[1] + len[2] + len[3] + `DMAC_FIFO_DEPTH + 3 + 25) * 40;

        wait (CCRESET_ === 1'b1);
        step();
        check_value("bus_req after reset", {31'd0, bus_req}, 32'd0);
        check_value("bgack after reset", {31'd0, bgack}, 32'd0);
        check_value("as/ds after reset", {30'd0, bus_out.as, bus_out.ds}, 32'd0);
        check_value("irq after reset", {31'd0, irq}, 32'd0);
        reg_read(`DMAC_REG_STAT, v);
        check_value("STAT after reset", v, 32'd0);

        w = $random(seed);
        reg_write(`DMAC_REG_ADDR, w);
        reg_read(`DMAC_REG_ADDR, v);
        check_value("ADDR readback", v, w);
        w = $random(seed);
        reg_write(`DMAC_REG_CNT, w);
        reg_read(`DMAC_REG_CNT, v);
        check_value("CNT readback", v, {16'd0, w[15:0]});
        reg_write(`DMAC_REG_CTRL, 32'd3);
        reg_read(`DMAC_REG_CTRL, v);
        check_value("CTRL readback", v, 32'd3);
        reg_write(`DMAC_REG_CTRL, 32'd0);

        run_p2m(32'h0000_0100, len[0]);
        run_p2m(32'h0000_1100, len[1]);
        run_overflow(32'h0000_0800);
        run_m2p(32'h0000_0400, len[2]);
        run_m2p(32'h0000_1800, len[3]);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- dmac_assert.sv
// bus protocol checks for the dma bus master, attached to cpu_bus_sm
`timescale 1ns/1ps

module dmac_assert (
    input logic               BCLK,
    input logic               CCRESET_,
    input logic               bus_req,
    input logic               bgack,
    input dmac_pkg::cpu_bus_t bus_out,
    input logic               grant_q,
    input logic [1:0]         dsack_q,
    input logic               sterm_q
);

    // strobes only during our own bus tenure
    strobe_in_tenure: assert property (@(posedge BCLK) disable iff (!CCRESET_)
        (bus_out.as || bus_out.ds) |-> bgack)
        else $error("address or data strobe driven without bgack");

    ds_needs_as: assert property (@(posedge BCLK) disable iff (!CCRESET_)
        bus_out.ds |-> bus_out.as)
        else $error("data strobe without address strobe");

    req_drop_after_grant: assert property (@(posedge BCLK) disable iff (!CCRESET_)
        $fell(bus_req) |-> $past(grant_q))
        else $error("bus request withdrawn before grant was seen");

    // low half follows a 16-bit acknowledge and sits two bytes above the high half
    low_half_addr: assert property (@(posedge BCLK) disable iff (!CCRESET_)
        $rose(bus_out.size1) |->
            (($past(dsack_q, 2) == 2'b10) && !$past(sterm_q, 2)
             && (bus_out.addr == $past(bus_out.addr, 2) + 32'd2)))
        else $error("size1 cycle not at addr+2 after a 16-bit termination");

endmodule

bind cpu_bus_sm dmac_assert u_assert (
    .BCLK     (BCLK),
    .CCRESET_ (CCRESET_),
    .bus_req  (bus_req),
    .bgack    (bgack),
    .bus_out  (bus_out),
    .grant_q  (grant_q),
    .dsack_q  (dsack_q),
    .sterm_q  (sterm_q)
);

//--- dmac_tb_clock.sv
// testbench clock and reset source, 10 ns bus clock with a two cycle reset
`timescale 1ns/1ps

module dmac_tb_clock (
    output logic BCLK,
    output logic CCRESET_
);

    initial begin
        BCLK     = 1'b0;
        CCRESET_ = 1'b0;
        forever #5 BCLK = ~BCLK;
    end

    initial begin
        repeat (2) @(posedge BCLK);
        #1 CCRESET_ = 1'b1;
    end

endmodule

//--- dmac_top.sv
// dma controller top level joining host registers, longword fifo and bus master
`timescale 1ns/1ps

module dmac_top (
    input  logic                BCLK,
    input  logic                CCRESET_,
    input  logic                reg_wr,
    input  logic [1:0]          reg_addr,
    input  dmac_pkg::word_t     reg_wdata,
    output dmac_pkg::word_t     reg_rdata,
    input  logic                periph_push,
    input  dmac_pkg::word_t     periph_wdata,
    input  logic                periph_pop,
    output dmac_pkg::word_t     periph_rdata,
    output logic                periph_avail,
    output logic                bus_req,
    output logic                bgack,
    output dmac_pkg::cpu_bus_t  bus_out,
    input  logic                bus_grant,
    input  logic [1:0]          dsack,
    input  logic                sterm,
    input  dmac_pkg::word_t     bus_rdata,
    output logic                irq
);

    dmac_pkg::dmac_ctrl_t ctrl;
    dmac_pkg::addr_t      start_addr;
    dmac_pkg::cnt_t       start_cnt;
    logic                 load;
    dmac_pkg::addr_t      cur_addr;
    dmac_pkg::cnt_t       cur_cnt;
    logic                 busy;
    logic                 done_pulse;
    logic                 overflow_pulse;
    logic                 sm_fifo_rd;
    logic                 sm_fifo_wr;
    dmac_pkg::word_t      sm_fifo_wdata;
    dmac_pkg::fifo_lvl_t  fifo_level;
    dmac_pkg::word_t      fifo_head;
    logic                 fifo_wr;
    logic                 fifo_rd;
    dmac_pkg::word_t      fifo_wdata;

    // peripheral fills the fifo when dir is 0, bus master fills it when dir is 1
    assign fifo_wr    = ctrl.dir ? sm_fifo_wr : periph_push;
    assign fifo_wdata = ctrl.dir ? sm_fifo_wdata : periph_wdata;
    assign fifo_rd    = ctrl.dir ? periph_pop : sm_fifo_rd;

    assign periph_rdata = fifo_head;
    assign periph_avail = (fifo_level != '0);

    dmac_regs u_regs (
        .BCLK           (BCLK),
        .CCRESET_       (CCRESET_),
        .reg_wr         (reg_wr),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .cur_addr       (cur_addr),
        .cur_cnt        (cur_cnt),
        .busy           (busy),
        .done_pulse     (done_pulse),
        .overflow_pulse (overflow_pulse),
        .reg_rdata      (reg_rdata),
        .ctrl           (ctrl),
        .start_addr     (start_addr),
        .start_cnt      (start_cnt),
        .load           (load),
        .irq            (irq)
    );

    dmac_fifo u_fifo (
        .BCLK           (BCLK),
        .CCRESET_       (CCRESET_),
        .wr             (fifo_wr),
        .wdata          (fifo_wdata),
        .rd             (fifo_rd),
        .rdata          (fifo_head),
        .level          (fifo_level),
        .overflow_pulse (overflow_pulse)
    );

    cpu_bus_sm u_bus_sm (
        .BCLK       (BCLK),
        .CCRESET_   (CCRESET_),
        .ctrl       (ctrl),
        .start_addr (start_addr),
        .start_cnt  (start_cnt),
        .load       (load),
        .bus_grant  (bus_grant),
        .dsack      (dsack),
        .sterm      (sterm),
        .bus_rdata  (bus_rdata),
        .fifo_level (fifo_level),
        .fifo_head  (fifo_head),
        .bus_req    (bus_req),
        .bgack      (bgack),
        .bus_out    (bus_out),
        .cur_addr   (cur_addr),
        .cur_cnt    (cur_cnt),
        .busy       (busy),
        .done_pulse (done_pulse),
        .fifo_rd    (sm_fifo_rd),
        .fifo_wr    (sm_fifo_wr),
        .fifo_wdata (sm_fifo_wdata)
    );

endmodule

//--- cpu_bus_sm.sv
// bus master that arbitrates, runs 32-bit and 16-bit port cycles and advances address and count
`timescale 1ns/1ps
`include "dmac_defines.svh"

module cpu_bus_sm (
    input  logic                 BCLK,
    input  logic                 CCRESET_,
    input  dmac_pkg::dmac_ctrl_t ctrl,
    input  dmac_pkg::addr_t      start_addr,
    input  dmac_pkg::cnt_t       start_cnt,
    input  logic                 load,
    input  logic                 bus_grant,
    input  logic [1:0]           dsack,
    input  logic                 sterm,
    input  dmac_pkg::word_t      bus_rdata,
    input  dmac_pkg::fifo_lvl_t  fifo_level,
    input  dmac_pkg::word_t      fifo_head,
    output logic                 bus_req,
    output logic                 bgack,
    output dmac_pkg::cpu_bus_t   bus_out,
    output dmac_pkg::addr_t      cur_addr,
    output dmac_pkg::cnt_t       cur_cnt,
    output logic                 busy,
    output logic                 done_pulse,
    output logic                 fifo_rd,
    output logic                 fifo_wr,
    output dmac_pkg::word_t      fifo_wdata
);

    localparam dmac_pkg::fifo_lvl_t LVL_FULL = `DMAC_FIFO_DEPTH;

    dmac_pkg::bus_state_e state;
    dmac_pkg::bus_state_e state_nxt;
    logic                 grant_q;
    logic [1:0]           dsack_q;
    logic                 sterm_q;
    dmac_pkg::word_t      rdata_q;
    dmac_pkg::word_t      data_q;
    logic                 low_half;
    logic                 strobe_on;
    logic                 term;
    logic                 port16;
    logic                 work_now;
    logic                 work_next;
    logic                 more;

    assign strobe_on = (state == dmac_pkg::ADDR) || (state == dmac_pkg::DATA);

    assign term   = sterm_q || (dsack_q != 2'b00);
    assign port16 = !sterm_q && (dsack_q == 2'b10);

    // room or data for one more word; next looks past the word moved in this ADVANCE
    assign work_now  = ctrl.dir ? (fifo_level < LVL_FULL) : (fifo_level != '0);
    assign work_next = ctrl.dir ? (fifo_level < LVL_FULL - 1'b1)
                                : (fifo_level > dmac_pkg::fifo_lvl_t'(1));
    assign more = (cur_cnt != dmac_pkg::cnt_t'(1)) && ctrl.enable && work_next;

    always_comb begin
        state_nxt = state;
        case (state)
            dmac_pkg::IDLE: begin
                if (load && (start_cnt != '0)) begin
                    state_nxt = dmac_pkg::ARB;
                end
            end
            dmac_pkg::ARB: begin
                if (!ctrl.enable) begin
                    state_nxt = dmac_pkg::IDLE;
                end else if (grant_q && work_now) begin
                    state_nxt = dmac_pkg::ADDR;
                end
            end
            dmac_pkg::ADDR: state_nxt = dmac_pkg::DATA;
            dmac_pkg::DATA: begin
                if (term) begin
                    state_nxt = (port16 && !low_half) ? dmac_pkg::LOW_HALF : dmac_pkg::ADVANCE;
                end
            end
            dmac_pkg::LOW_HALF: state_nxt = dmac_pkg::ADDR;
            dmac_pkg::ADVANCE:  state_nxt = more ? dmac_pkg::ADDR : dmac_pkg::RELEASE;
            dmac_pkg::RELEASE: begin
                state_nxt = ((cur_cnt != '0) && ctrl.enable) ? dmac_pkg::ARB : dmac_pkg::IDLE;
            end
            default: state_nxt = dmac_pkg::IDLE;
        endcase
    end

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state      <= dmac_pkg::IDLE;
            grant_q    <= 1'b0;
            dsack_q    <= 2'b00;
            sterm_q    <= 1'b0;
            low_half   <= 1'b0;
            cur_addr   <= '0;
            cur_cnt    <= '0;
            done_pulse <= 1'b0;
        end else begin
            state   <= state_nxt;
            grant_q <= bus_grant;
            // termination is only taken while the strobes are out, stale acks are dropped
            dsack_q <= strobe_on ? dsack : 2'b00;
            sterm_q <= strobe_on && sterm;
            done_pulse <= 1'b0;
            if ((state == dmac_pkg::IDLE) && load) begin
                cur_addr   <= start_addr;
                cur_cnt    <= start_cnt;
                done_pulse <= (start_cnt == '0);
            end
            if ((state == dmac_pkg::DATA) && term) begin
                low_half <= port16 && !low_half;
            end
            if (state == dmac_pkg::ADVANCE) begin
                cur_addr   <= cur_addr + 32'd4;
                cur_cnt    <= cur_cnt - 1'b1;
                done_pulse <= (cur_cnt == dmac_pkg::cnt_t'(1));
            end
        end
    end

    // read data, a 16-bit port answers on D31:16 for both halves
    always_ff @(posedge BCLK) begin
        rdata_q <= bus_rdata;
        if ((state == dmac_pkg::DATA) && term) begin
            if (low_half) begin
                data_q[15:0] <= port16 ? rdata_q[31:16] : rdata_q[15:0];
            end else if (port16) begin
                data_q[31:16] <= rdata_q[31:16];
            end else begin
                data_q <= rdata_q;
            end
        end
    end

    assign busy    = (state != dmac_pkg::IDLE);
    assign bus_req = (state == dmac_pkg::ARB) && ctrl.enable && work_now;
    assign bgack   = strobe_on || (state == dmac_pkg::LOW_HALF)
                     || (state == dmac_pkg::ADVANCE);

    assign fifo_rd    = (state == dmac_pkg::ADVANCE) && !ctrl.dir;
    assign fifo_wr    = (state == dmac_pkg::ADVANCE) && ctrl.dir;
    assign fifo_wdata = data_q;

    always_comb begin
        bus_out.as    = strobe_on;
        bus_out.ds    = (state == dmac_pkg::DATA);
        bus_out.rw    = ctrl.dir;
        bus_out.size1 = strobe_on && low_half;
        bus_out.addr  = low_half ? cur_addr + 32'd2 : cur_addr;
        // low word goes out on both halves so a 16-bit port finds it on D31:16
        bus_out.wdata = low_half ? {fifo_head[15:0], fifo_head[15:0]} : fifo_head;
    end

endmodule

//--- dmac_fifo.sv
// longword fifo between the peripheral strobes and the bus master, flags dropped pushes
`timescale 1ns/1ps
`include "dmac_defines.svh"

module dmac_fifo (
    input  logic                BCLK,
    input  logic                CCRESET_,
    input  logic                wr,
    input  dmac_pkg::word_t     wdata,
    input  logic                rd,
    output dmac_pkg::word_t     rdata,
    output dmac_pkg::fifo_lvl_t level,
    output logic                overflow_pulse
);

    localparam dmac_pkg::fifo_lvl_t LVL_FULL = `DMAC_FIFO_DEPTH;

    dmac_pkg::word_t          mem [0:`DMAC_FIFO_DEPTH-1];
    logic [`DMAC_FIFO_AW-1:0] wptr;
    logic [`DMAC_FIFO_AW-1:0] rptr;
    logic                     full;
    logic                     empty;
    logic                     do_wr;
    logic                     do_rd;

    assign full  = (level == LVL_FULL);
    assign empty = (level == '0);

    // a read frees the slot in the same cycle, so a full fifo still takes a write
    assign do_rd = rd && !empty;
    assign do_wr = wr && (!full || do_rd);

    always_ff @(posedge BCLK) begin
        if (do_wr) begin
            mem[wptr] <= wdata;
        end
    end

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            wptr           <= '0;
            rptr           <= '0;
            level          <= '0;
            overflow_pulse <= 1'b0;
        end else begin
            if (do_wr) begin
                wptr <= wptr + 1'b1;
            end
            if (do_rd) begin
                rptr <= rptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
            overflow_pulse <= wr && !do_wr;
        end
    end

    // head of queue, valid while level is nonzero
    assign rdata = mem[rptr];

endmodule

//--- dmac_regs.sv
// host register block with control, address, count and sticky status, drives the interrupt
`timescale 1ns/1ps
`include "dmac_defines.svh"

module dmac_regs (
    input  logic                 BCLK,
    input  logic                 CCRESET_,
    input  logic                 reg_wr,
    input  logic [1:0]           reg_addr,
    input  dmac_pkg::word_t      reg_wdata,
    input  dmac_pkg::addr_t      cur_addr,
    input  dmac_pkg::cnt_t       cur_cnt,
    input  logic                 busy,
    input  logic                 done_pulse,
    input  logic                 overflow_pulse,
    output dmac_pkg::word_t      reg_rdata,
    output dmac_pkg::dmac_ctrl_t ctrl,
    output dmac_pkg::addr_t      start_addr,
    output dmac_pkg::cnt_t       start_cnt,
    output logic                 load,
    output logic                 irq
);

    logic           wr_ctrl;
    logic           wr_addr;
    logic           wr_cnt;
    logic           wr_stat;
    logic           done_q;
    logic           ovf_q;
    dmac_pkg::cnt_t rd_cnt;

    assign wr_ctrl = reg_wr && (reg_addr == `DMAC_REG_CTRL);
    assign wr_addr = reg_wr && (reg_addr == `DMAC_REG_ADDR);
    assign wr_cnt  = reg_wr && (reg_addr == `DMAC_REG_CNT);
    assign wr_stat = reg_wr && (reg_addr == `DMAC_REG_STAT);

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            ctrl       <= '0;
            start_addr <= '0;
            start_cnt  <= '0;
            load       <= 1'b0;
            done_q     <= 1'b0;
            ovf_q      <= 1'b0;
            irq        <= 1'b0;
        end else begin
            if (wr_ctrl) begin
                ctrl <= dmac_pkg::dmac_ctrl_t'(reg_wdata[2:0]);
            end
            // follow the bus master while it runs so the final position is kept afterwards
            if (busy) begin
                start_addr <= cur_addr;
                start_cnt  <= cur_cnt;
            end else begin
                if (wr_addr) begin
                    start_addr <= reg_wdata;
                end
                if (wr_cnt) begin
                    start_cnt <= reg_wdata[`DMAC_CNT_W-1:0];
                end
            end
            load <= wr_ctrl && reg_wdata[2];
            // a new event wins over a clear in the same cycle
            if (done_pulse) begin
                done_q <= 1'b1;
            end else if (wr_stat && reg_wdata[0]) begin
                done_q <= 1'b0;
            end
            if (overflow_pulse) begin
                ovf_q <= 1'b1;
            end else if (wr_stat && reg_wdata[0]) begin
                ovf_q <= 1'b0;
            end
            irq <= done_q && ctrl.irq_en;
        end
    end

    assign rd_cnt = busy ? cur_cnt : start_cnt;

    always_comb begin
        reg_rdata = '0;
        case (reg_addr)
            `DMAC_REG_CTRL: reg_rdata = dmac_pkg::word_t'(ctrl);
            `DMAC_REG_ADDR: reg_rdata = busy ? cur_addr : start_addr;
            `DMAC_REG_CNT:  reg_rdata = dmac_pkg::word_t'(rd_cnt);
            default: begin
                reg_rdata[`DMAC_STAT_DONE] = done_q;
                reg_rdata[`DMAC_STAT_OVF]  = ovf_q;
                reg_rdata[`DMAC_STAT_BUSY] = busy;
            end
        endcase
    end

endmodule

//--- dmac_pkg.sv
// dma controller shared types for data words, bus state and bus signal bundles
`include "dmac_defines.svh"

package dmac_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [`DMAC_CNT_W-1:0] cnt_t;

    // one bit wider than the pointer so that full and empty differ
    typedef logic [`DMAC_FIFO_AW:0] fifo_lvl_t;

    typedef enum logic [2:0] {
        IDLE,
        ARB,
        ADDR,
        DATA,
        LOW_HALF,
        ADVANCE,
        RELEASE
    } bus_state_e;

    // dir set means memory to peripheral
    typedef struct packed {
        logic enable;
        logic dir;
        logic irq_en;
    } dmac_ctrl_t;

    // rw high is a read; size1 marks the low half cycle of a 16-bit port
    typedef struct packed {
        logic  as;
        logic  ds;
        logic  rw;
        logic  size1;
        addr_t addr;
        word_t wdata;
    } cpu_bus_t;

endpackage

//--- dmac_defines.svh
// dma controller sizing and host register map

`ifndef DMAC_DEFINES_SVH
`define DMAC_DEFINES_SVH

// longword fifo between peripheral and bus master
`define DMAC_FIFO_DEPTH 8
`define DMAC_FIFO_AW    3

// remaining word count
`define DMAC_CNT_W      16

// host register offsets, 2-bit register address
`define DMAC_REG_CTRL   2'd0
`define DMAC_REG_ADDR   2'd1
`define DMAC_REG_CNT    2'd2
`define DMAC_REG_STAT   2'd3

// status register bits
`define DMAC_STAT_DONE  0
`define DMAC_STAT_OVF   1
`define DMAC_STAT_BUSY  2

`endif
